//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = vga_tb
FILELIST = project.f
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/vga_tb.sv
// VGA framebuffer output testbench
`timescale 1ns/1ps

module vga_tb;
	import vga_csr_pkg::*;

	localparam logic [3:0] PAGE = 4'h2; // DUT CSR page.
	localparam logic [3:0] OTHER_PAGE = 4'h5;
	localparam int HRES = 8, HSS = 10, HSE = 12, HSCAN = 14;
	localparam int VRES = 4, VSS = 5, VSE = 6, VSCAN = 7;
	localparam int BURSTS = 8;
	localparam logic [25:0] BASE = 26'h1000;
	localparam int MIN_REQS = HRES * VRES * 2 / 32; // Bursts that a frame shows.
	localparam int FRAME_SLOW = HSCAN * VSCAN * 4; // Cycles per frame at divide 4.
	localparam longint TIMEOUT_NS = (16 * FRAME_SLOW + 500) * 20;

	logic sys_clk, arst_n, csr_we, fml_ack;
	logic [13:0] csr_a;
	logic [31:0] csr_di, csr_do;
	logic [25:0] fml_adr;
	logic [63:0] fml_di;
	logic fml_stb, vga_psave_n, vga_hsync_n, vga_vsync_n, vga_sync_n, vga_blank_n;
	logic [7:0] vga_r, vga_g, vga_b;
	logic vga_clkout;

	integer seed = 15;
	int err_cnt = 0, test_err_base = 0, tests_run = 0, tests_failed = 0;
	logic chk_sync = 1'b0; // Sync checkers armed.
	int exp_div = 2; // Expected sys_clk cycles per pixel.
	int exp_idx = 0, pix_checked = 0, underruns = 0;
	int frame_reqs = 0, frames_fetched = 0;
	logic [25:0] last_adr;
	logic [15:0] px;
	logic vs_seen;
	int hs_run, vs_run, line_cnt, sh_run, ck_cnt;
	logic hs_arm, vs_arm, ln_arm, sh_arm, ck_arm, hs_prev, vs_prev, ck_prev;

	vga #(.csr_addr(PAGE)) DUT (.*);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired at %0t, DUT stopped making progress", $time);
		$display("Testbench failed");
		$finish;
	end

	task automatic report_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
		$display("ERR t=%0t %s got %0h expected %0h", $time, sig, got, exp);
		err_cnt++;
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt != test_err_base)
			tests_failed++;
		$display("test %-12s %s, %0d errors", name,
			(err_cnt == test_err_base) ? "ok" : "FAILED", err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	// Reference pixel for byte address a, slot k (0 is the top half).
	function automatic logic [15:0] pixel_at(input logic [25:0] a, input int k);
		return {1'b1, 2'(k), a[12:0]} ^ {3'b000, a[25:13]}; // Bit 15 set, never black.
	endfunction

	function automatic logic [63:0] word_at(input logic [25:0] a);
		return {pixel_at(a, 0), pixel_at(a, 1), pixel_at(a, 2), pixel_at(a, 3)};
	endfunction

	function automatic logic [23:0] expand(input logic [15:0] p);
		return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
	endfunction

	task automatic csr_write(input csr_reg_e r, input logic [31:0] v);
		@(posedge sys_clk);
		#1 csr_a = {PAGE, 6'd0, 4'(r)};
		csr_we = 1'b1;
		csr_di = v;
		@(posedge sys_clk);
		#1 csr_we = 1'b0;
	endtask

	task automatic csr_check(input logic [3:0] page, input csr_reg_e r, input logic [31:0] exp);
		@(posedge sys_clk);
		#1 csr_a = {page, 6'd0, 4'(r)};
		@(posedge sys_clk); // Read data registered here.
		#1 assert (csr_do == exp) else report_value({"csr_do ", r.name()}, csr_do, exp);
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(negedge vga_vsync_n);
	endtask

	// Memory model with a random ack delay and four beats after the ack.
	initial begin
		int delay;
		logic [25:0] adr;
		fml_ack = 1'b0;
		fml_di = '0;
		forever begin
			@(posedge sys_clk);
			if (fml_stb) begin
				adr = fml_adr;
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) @(posedge sys_clk);
				if (adr == BASE) begin // First request of a frame.
					if (frame_reqs != 0 && (frame_reqs > BURSTS || frame_reqs < MIN_REQS))
						report_failure($sformatf("%0d requests in one frame", frame_reqs));
					frame_reqs = 1;
					frames_fetched++;
				end else begin
					assert (adr == last_adr + 26'd32) else report_value("fml_adr", adr, last_adr + 32);
					frame_reqs++;
				end
				last_adr = adr;
				#1 fml_ack = 1'b1;
				@(posedge sys_clk);
				#1 fml_ack = 1'b0;
				for (int b = 0; b < 4; b++) begin
					fml_di = word_at(adr + 26'(8 * b));
					if (b < 3)
						@(posedge sys_clk) #1;
				end
			end
		end
	end

	// Pixel stream in blank_n-high order; black marks an underrun.
	always @(posedge vga_clkout) begin
		if (arst_n) begin
			if (vga_blank_n) begin
				if ({vga_r, vga_g, vga_b} == 24'd0) begin
					underruns++;
				end else begin
					px = pixel_at(BASE + 26'(8 * (exp_idx / 4)), exp_idx % 4);
					assert ({vga_r, vga_g, vga_b} == expand(px))
						else report_value("vga_rgb", {vga_r, vga_g, vga_b}, expand(px));
					exp_idx++;
					pix_checked++;
				end
			end
			if (!vga_vsync_n && vs_seen)
				exp_idx = 0; // Every frame starts over at the base address.
			vs_seen = vga_vsync_n;
		end
	end

	// Sync widths and line length in pixel periods.
	always @(posedge vga_clkout) begin
		if (!chk_sync) begin
			hs_arm = 1'b0;
			vs_arm = 1'b0;
			ln_arm = 1'b0;
			hs_run = 0;
			vs_run = 0;
		end else begin
			line_cnt++;
			if (!vga_hsync_n) begin
				if (hs_prev) begin
					if (ln_arm)
						assert (line_cnt == HSCAN + 1)
							else report_value("line_length", line_cnt - 1, HSCAN);
					ln_arm = 1'b1;
					line_cnt = 1;
				end
				hs_run++;
			end else begin
				if (hs_run != 0 && hs_arm)
					assert (hs_run == HSE - HSS)
						else report_value("vga_hsync_n width", hs_run, HSE - HSS);
				hs_run = 0;
				hs_arm = 1'b1;
			end
			if (!vga_vsync_n) begin
				vs_run++;
			end else begin
				if (vs_run != 0 && vs_arm)
					assert (vs_run == (VSE - VSS) * HSCAN)
						else report_value("vga_vsync_n width", vs_run, (VSE - VSS) * HSCAN);
				vs_run = 0;
				vs_arm = 1'b1;
			end
		end
		hs_prev = vga_hsync_n;
	end

	// Pixel clock period and hsync width in sys_clk cycles.
	always @(posedge sys_clk) begin
		if (!chk_sync) begin
			ck_arm = 1'b0;
			sh_arm = 1'b0;
			ck_cnt = 0;
			sh_run = 0;
		end else begin
			ck_cnt++;
			if (vga_clkout && !ck_prev) begin
				if (ck_arm)
					assert (ck_cnt == exp_div) else report_value("vga_clkout period", ck_cnt, exp_div);
				ck_arm = 1'b1;
				ck_cnt = 0;
			end
			if (!vga_hsync_n) begin
				sh_run++;
			end else begin
				if (sh_run != 0 && sh_arm)
					assert (sh_run == (HSE - HSS) * exp_div)
						else report_value("hsync cycles", sh_run, (HSE - HSS) * exp_div);
				sh_run = 0;
				sh_arm = 1'b1;
			end
		end
		ck_prev = vga_clkout;
	end

	a_adr_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
		fml_stb && !fml_ack |=> $stable(fml_adr))
		else report_failure("fml_adr changed while fml_stb waited for ack");
	a_blank_black: assert property (@(posedge sys_clk) disable iff (!arst_n)
		!vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'd0)
		else report_failure("color pads not black during blanking");

	initial begin
		arst_n = 1'b0;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		repeat (3) @(posedge sys_clk);
		#1 arst_n = 1'b1;

		repeat (2) @(posedge sys_clk);
		#1;
		assert (fml_stb == 1'b0) else report_value("fml_stb", fml_stb, 0);
		assert (vga_psave_n == 1'b0) else report_value("vga_psave_n", vga_psave_n, 0);
		assert (vga_blank_n == 1'b0) else report_value("vga_blank_n", vga_blank_n, 0);
		assert (vga_hsync_n && vga_vsync_n && vga_sync_n)
			else report_failure("sync pads not idle after reset");
		end_test("reset");

		csr_write(REG_HRES, HRES);
		csr_write(REG_HSYNC_START, HSS);
		csr_write(REG_HSYNC_END, HSE);
		csr_write(REG_HSCAN, HSCAN);
		csr_write(REG_VRES, VRES);
		csr_write(REG_VSYNC_START, VSS);
		csr_write(REG_VSYNC_END, VSE);
		csr_write(REG_VSCAN, VSCAN);
		csr_write(REG_BASEADDR, 32'(BASE));
		csr_write(REG_FRAME_BURSTS, BURSTS);
		csr_check(PAGE, REG_HRES, HRES);
		csr_check(PAGE, REG_HSYNC_START, HSS);
		csr_check(PAGE, REG_HSYNC_END, HSE);
		csr_check(PAGE, REG_HSCAN, HSCAN);
		csr_check(PAGE, REG_VRES, VRES);
		csr_check(PAGE, REG_VSYNC_START, VSS);
		csr_check(PAGE, REG_VSYNC_END, VSE);
		csr_check(PAGE, REG_VSCAN, VSCAN);
		csr_check(PAGE, REG_BASEADDR, 32'(BASE));
		csr_check(PAGE, REG_FRAME_BURSTS, BURSTS);
		csr_check(OTHER_PAGE, REG_HRES, 32'd0); // Foreign page.
		csr_write(REG_CTRL, 32'd1);
		csr_check(PAGE, REG_CTRL, 32'd1);
		@(posedge fml_stb); // Fetch starts after the first frame start.
		assert (vga_psave_n == 1'b1) else report_value("vga_psave_n", vga_psave_n, 1);
		csr_check(PAGE, REG_BASEADDR_ACT, 32'(BASE));
		end_test("csr");

		chk_sync = 1'b1;
		wait_frames(3);
		end_test("sync");

		wait_frames(3);
		if (pix_checked == 0)
			report_failure("no visible pixel carried framebuffer data");
		end_test("pixels");

		wait_frames(2);
		if (frames_fetched < 3)
			report_failure("fetch engine did not restart every frame");
		end_test("backpressure");

		wait_frames(1); // Switch inside the vsync line, no visible pixels.
		chk_sync = 1'b0;
		csr_write(REG_CTRL, 32'd3);
		exp_div = 4;
		wait_frames(1);
		chk_sync = 1'b1;
		wait_frames(2);
		end_test("divider");

		$display("%0d tests, %0d failed, %0d errors, %0d pixels checked, %0d underruns",
			tests_run, tests_failed, err_cnt, pix_checked, underruns);
		if (err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- include/vga_consts.svh
// VGA framebuffer constants
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

`define VGA_FML_DEPTH 26 // Memory byte address width.
`define VGA_FIFO_DEPTH 16 // Words in the pixel FIFO.
`define VGA_BURST_LEN 4 // Beats per memory request.

// 640x480 at 60 Hz after reset.
`define VGA_RST_HRES 640
`define VGA_RST_HSYNC_START 656
`define VGA_RST_HSYNC_END 752
`define VGA_RST_HSCAN 800
`define VGA_RST_VRES 480
`define VGA_RST_VSYNC_START 491
`define VGA_RST_VSYNC_END 493
`define VGA_RST_VSCAN 525
`define VGA_RST_BURSTS 19200 // 640x480 RGB565 in 32-byte bursts.

`endif

//--- project.f
+incdir+include
source/vga_csr_pkg.sv
source/vga_video_pkg.sv
source/vga_ctrl_regs.sv
source/vga_timing_gen.sv
source/vga_fetch.sv
source/vga_pixel_fifo.sv
source/vga_pixel_out.sv
source/vga.sv
dv/vga_tb.sv

//--- source/vga.sv
// VGA framebuffer output top
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic arst_n,
	input logic [13:0] csr_a,
	input logic csr_we,
	input logic [31:0] csr_di,
	output logic [31:0] csr_do,
	output vga_csr_pkg::fml_addr_t fml_adr,
	output logic fml_stb,
	input logic fml_ack,
	input vga_video_pkg::fb_word_t fml_di,
	output logic vga_psave_n,
	output logic vga_hsync_n,
	output logic vga_vsync_n,
	output logic vga_sync_n,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_clkout
);
	import vga_csr_pkg::*;
	import vga_video_pkg::*;

	logic [1:0] div_cnt; // Free-running pixel divider.
	logic pix_ce;
	logic out_enable, clk_div_sel;
	timing_t hres, hsync_start, hsync_end, hscan;
	timing_t vres, vsync_start, vsync_end, vscan;
	fml_addr_t baseaddress, baseaddress_act;
	burst_cnt_t frame_bursts;
	logic active, hsync, vsync, frame_start;
	logic fifo_wr, fifo_rd, fifo_empty;
	fb_word_t fifo_wdata, fifo_rdata;
	fifo_cnt_t fifo_free;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 2'd1;
	end

	// Select 0 gives 1 in 2 cycles, select 1 gives 1 in 4.
	assign pix_ce = clk_div_sel ? (div_cnt == 2'b11) : div_cnt[0];
	assign vga_clkout = clk_div_sel ? div_cnt[1] : div_cnt[0];

	vga_ctrl_regs #(.csr_addr(csr_addr)) u_regs (
		.sys_clk, .arst_n, .csr_a, .csr_we, .csr_di, .csr_do,
		.out_enable, .clk_div_sel,
		.hres, .hsync_start, .hsync_end, .hscan,
		.vres, .vsync_start, .vsync_end, .vscan,
		.baseaddress, .frame_bursts, .baseaddress_act
	);

	vga_timing_gen u_timing (
		.sys_clk, .arst_n, .pix_ce, .enable(out_enable),
		.hres, .hsync_start, .hsync_end, .hscan,
		.vres, .vsync_start, .vsync_end, .vscan,
		.active, .hsync, .vsync, .frame_start
	);

	vga_fetch u_fetch (
		.sys_clk, .arst_n, .frame_start, .enable(out_enable),
		.baseaddress, .frame_bursts, .baseaddress_act,
		.fml_adr, .fml_stb, .fml_ack, .fml_di,
		.fifo_wr, .fifo_wdata, .fifo_free
	);

	vga_pixel_fifo u_fifo (
		.sys_clk, .arst_n, .clear(frame_start), // Flush per frame.
		.wr(fifo_wr), .wdata(fifo_wdata), .rd(fifo_rd), .rdata(fifo_rdata),
		.empty(fifo_empty), .free(fifo_free)
	);

	vga_pixel_out u_out (
		.sys_clk, .arst_n, .pix_ce, .enable(out_enable),
		.active, .hsync, .vsync, .word(fifo_rdata), .empty(fifo_empty),
		.pop(fifo_rd), .vga_psave_n, .vga_hsync_n, .vga_vsync_n,
		.vga_sync_n, .vga_blank_n, .vga_r, .vga_g, .vga_b
	);

	// An accepted burst always finds room for all its beats.
	a_burst_room: assert property (@(posedge sys_clk) disable iff (!arst_n)
		(u_fetch.state == F_REQ && fml_ack) |-> fifo_free >= fifo_cnt_t'(`VGA_BURST_LEN));

endmodule

//--- source/vga_csr_pkg.sv
// VGA register map types
`include "vga_consts.svh"

package vga_csr_pkg;

	typedef enum logic [3:0] {
		REG_CTRL = 4'd0, // Bit0 output enable, bit1 divider select.
		REG_HRES = 4'd1,
		REG_HSYNC_START = 4'd2,
		REG_HSYNC_END = 4'd3,
		REG_HSCAN = 4'd4,
		REG_VRES = 4'd5,
		REG_VSYNC_START = 4'd6,
		REG_VSYNC_END = 4'd7,
		REG_VSCAN = 4'd8,
		REG_BASEADDR = 4'd9,
		REG_BASEADDR_ACT = 4'd10, // Read only.
		REG_FRAME_BURSTS = 4'd11
	} csr_reg_e;

	typedef logic [10:0] timing_t; // Pixel or line count.
	typedef logic [15:0] burst_cnt_t; // Requests per frame.
	typedef logic [`VGA_FML_DEPTH-1:0] fml_addr_t; // Framebuffer byte address.

endpackage

//--- source/vga_ctrl_regs.sv
// VGA configuration registers
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_ctrl_regs #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic arst_n,
	input logic [13:0] csr_a,
	input logic csr_we,
	input logic [31:0] csr_di,
	output logic [31:0] csr_do,
	output logic out_enable,
	output logic clk_div_sel,
	output vga_csr_pkg::timing_t hres,
	output vga_csr_pkg::timing_t hsync_start,
	output vga_csr_pkg::timing_t hsync_end,
	output vga_csr_pkg::timing_t hscan,
	output vga_csr_pkg::timing_t vres,
	output vga_csr_pkg::timing_t vsync_start,
	output vga_csr_pkg::timing_t vsync_end,
	output vga_csr_pkg::timing_t vscan,
	output vga_csr_pkg::fml_addr_t baseaddress,
	output vga_csr_pkg::burst_cnt_t frame_bursts,
	input vga_csr_pkg::fml_addr_t baseaddress_act
);
	import vga_csr_pkg::*;

	logic csr_sel;
	csr_reg_e reg_idx;
	logic [31:0] rdata;

	assign csr_sel = (csr_a[13:10] == csr_addr); // Page match.
	assign reg_idx = csr_reg_e'(csr_a[3:0]);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			out_enable <= 1'b0; // Pads start powered down.
			clk_div_sel <= 1'b0;
			hres <= timing_t'(`VGA_RST_HRES);
			hsync_start <= timing_t'(`VGA_RST_HSYNC_START);
			hsync_end <= timing_t'(`VGA_RST_HSYNC_END);
			hscan <= timing_t'(`VGA_RST_HSCAN);
			vres <= timing_t'(`VGA_RST_VRES);
			vsync_start <= timing_t'(`VGA_RST_VSYNC_START);
			vsync_end <= timing_t'(`VGA_RST_VSYNC_END);
			vscan <= timing_t'(`VGA_RST_VSCAN);
			baseaddress <= '0;
			frame_bursts <= burst_cnt_t'(`VGA_RST_BURSTS);
		end else if (csr_sel && csr_we) begin
			case (reg_idx)
				REG_CTRL: begin
					out_enable <= csr_di[0];
					clk_div_sel <= csr_di[1];
				end
				REG_HRES: hres <= csr_di[10:0];
				REG_HSYNC_START: hsync_start <= csr_di[10:0];
				REG_HSYNC_END: hsync_end <= csr_di[10:0];
				REG_HSCAN: hscan <= csr_di[10:0];
				REG_VRES: vres <= csr_di[10:0];
				REG_VSYNC_START: vsync_start <= csr_di[10:0];
				REG_VSYNC_END: vsync_end <= csr_di[10:0];
				REG_VSCAN: vscan <= csr_di[10:0];
				REG_BASEADDR: baseaddress <= csr_di[`VGA_FML_DEPTH-1:0];
				REG_FRAME_BURSTS: frame_bursts <= csr_di[15:0];
				default: ; // Read-only or unmapped.
			endcase
		end
	end

	always_comb begin
		case (reg_idx)
			REG_CTRL: rdata = {30'd0, clk_div_sel, out_enable};
			REG_HRES: rdata = 32'(hres);
			REG_HSYNC_START: rdata = 32'(hsync_start);
			REG_HSYNC_END: rdata = 32'(hsync_end);
			REG_HSCAN: rdata = 32'(hscan);
			REG_VRES: rdata = 32'(vres);
			REG_VSYNC_START: rdata = 32'(vsync_start);
			REG_VSYNC_END: rdata = 32'(vsync_end);
			REG_VSCAN: rdata = 32'(vscan);
			REG_BASEADDR: rdata = 32'(baseaddress);
			REG_BASEADDR_ACT: rdata = 32'(baseaddress_act);
			REG_FRAME_BURSTS: rdata = 32'(frame_bursts);
			default: rdata = '0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			csr_do <= '0;
		else
			csr_do <= csr_sel ? rdata : '0; // Other pages read zero.
	end

	// Another slot's access leaves the read bus quiet.
	a_unsel_zero: assert property (@(posedge sys_clk) disable iff (!arst_n)
		!csr_sel |=> csr_do == '0);

endmodule

//--- source/vga_fetch.sv
// Framebuffer burst fetch engine
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_fetch (
	input logic sys_clk,
	input logic arst_n,
	input logic frame_start,
	input logic enable,
	input vga_csr_pkg::fml_addr_t baseaddress,
	input vga_csr_pkg::burst_cnt_t frame_bursts,
	output vga_csr_pkg::fml_addr_t baseaddress_act,
	output vga_csr_pkg::fml_addr_t fml_adr,
	output logic fml_stb,
	input logic fml_ack,
	input vga_video_pkg::fb_word_t fml_di,
	output logic fifo_wr,
	output vga_video_pkg::fb_word_t fifo_wdata,
	input vga_video_pkg::fifo_cnt_t fifo_free
);
	import vga_csr_pkg::*;
	import vga_video_pkg::*;

	localparam int BURST_BYTES = `VGA_BURST_LEN * 8; // 64-bit beats.

	fetch_state_e state;
	fml_addr_t cur_adr;
	burst_cnt_t burst_cnt; // Requests issued this frame.
	logic [$clog2(`VGA_BURST_LEN)-1:0] beat_cnt;
	logic restart_pend; // Frame start seen, reload pending.
	logic can_issue;
	logic waiting;

	assign can_issue = enable && !restart_pend && (burst_cnt < frame_bursts) &&
		(fifo_free >= fifo_cnt_t'(`VGA_BURST_LEN)); // Beats cannot be stalled.
	assign waiting = (state == F_IDLE) || (state == F_DONE);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= F_DONE; // Nothing to fetch before the first frame.
			cur_adr <= '0;
			burst_cnt <= '0;
			beat_cnt <= '0;
			restart_pend <= 1'b0;
			baseaddress_act <= '0;
		end else begin
			case (state)
				F_IDLE: if (can_issue) state <= F_REQ;
				F_REQ: if (fml_ack) begin
					state <= F_DATA;
					beat_cnt <= '0;
					cur_adr <= cur_adr + fml_addr_t'(BURST_BYTES);
					burst_cnt <= burst_cnt + 16'd1;
				end
				F_DATA: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == $bits(beat_cnt)'(`VGA_BURST_LEN - 1))
						state <= (burst_cnt >= frame_bursts) ? F_DONE : F_IDLE;
				end
				default: ; // F_DONE holds.
			endcase
			if (waiting && restart_pend) begin
				state <= F_IDLE; // Rewind to the new frame.
				cur_adr <= baseaddress_act;
				burst_cnt <= '0;
				restart_pend <= 1'b0;
			end
			if (frame_start) begin
				restart_pend <= 1'b1;
				baseaddress_act <= baseaddress; // Latched once per frame.
			end
		end
	end

	assign fml_stb = (state == F_REQ);
	assign fml_adr = cur_adr;
	// Beats of a burst cut by frame start are dropped.
	assign fifo_wr = (state == F_DATA) && !restart_pend && !frame_start;
	assign fifo_wdata = fml_di;

	// Request address holds until the memory takes it.
	a_adr_stable: assert property (@(posedge sys_clk) disable iff (!arst_n)
		fml_stb && !fml_ack |=> fml_stb && $stable(fml_adr));

endmodule

//--- source/vga_pixel_fifo.sv
// Framebuffer word FIFO
`timescale 1ns/1ps
`include "vga_consts.svh"

module vga_pixel_fifo (
	input logic sys_clk,
	input logic arst_n,
	input logic clear,
	input logic wr,
	input vga_video_pkg::fb_word_t wdata,
	input logic rd,
	output vga_video_pkg::fb_word_t rdata,
	output logic empty,
	output vga_video_pkg::fifo_cnt_t free
);
	import vga_video_pkg::*;

	localparam int AW = $clog2(`VGA_FIFO_DEPTH);

	fb_word_t mem [`VGA_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	fifo_cnt_t count;

	always_ff @(posedge sys_clk) begin
		if (wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0; // New frame, drop leftovers.
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + fifo_cnt_t'(wr) - fifo_cnt_t'(rd);
		end
	end

	assign rdata = mem[rd_ptr]; // Show-ahead.
	assign empty = (count == '0);
	assign free = fifo_cnt_t'(`VGA_FIFO_DEPTH) - count;

	a_no_overflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
		wr && !clear |-> free != '0);
	a_no_underflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
		rd && !clear |-> !empty);

endmodule

//--- source/vga_pixel_out.sv
// RGB565 unpack and VGA pad registers
`timescale 1ns/1ps

module vga_pixel_out (
	input logic sys_clk,
	input logic arst_n,
	input logic pix_ce,
	input logic enable,
	input logic active,
	input logic hsync,
	input logic vsync,
	input vga_video_pkg::fb_word_t word,
	input logic empty,
	output logic pop,
	output logic vga_psave_n,
	output logic vga_hsync_n,
	output logic vga_vsync_n,
	output logic vga_sync_n,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import vga_video_pkg::*;

	logic [1:0] pix_idx; // Pixel within word, 0 is the top half.
	logic take;
	rgb565_t pix;

	assign pix = word[{~pix_idx, 4'b0000} +: 16];
	assign take = pix_ce && active && !empty; // Underrun shows black.
	assign pop = take && (pix_idx == 2'd3);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			pix_idx <= '0;
		else if (empty)
			pix_idx <= '0; // A flushed FIFO restarts at the top half.
		else if (take)
			pix_idx <= pix_idx + 2'd1;
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_psave_n <= 1'b0;
			vga_hsync_n <= 1'b1;
			vga_vsync_n <= 1'b1;
			vga_sync_n <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (pix_ce) begin
			vga_psave_n <= enable;
			vga_hsync_n <= !hsync;
			vga_vsync_n <= !vsync;
			vga_sync_n <= !(hsync ^ vsync); // Composite sync.
			vga_blank_n <= active;
			vga_r <= take ? {pix.r, pix.r[4:2]} : 8'd0; // Top bits refill the low ones.
			vga_g <= take ? {pix.g, pix.g[5:4]} : 8'd0;
			vga_b <= take ? {pix.b, pix.b[4:2]} : 8'd0;
		end
	end

endmodule

//--- source/vga_timing_gen.sv
// VGA sync and active-video timing
`timescale 1ns/1ps

module vga_timing_gen (
	input logic sys_clk,
	input logic arst_n,
	input logic pix_ce,
	input logic enable,
	input vga_csr_pkg::timing_t hres,
	input vga_csr_pkg::timing_t hsync_start,
	input vga_csr_pkg::timing_t hsync_end,
	input vga_csr_pkg::timing_t hscan,
	input vga_csr_pkg::timing_t vres,
	input vga_csr_pkg::timing_t vsync_start,
	input vga_csr_pkg::timing_t vsync_end,
	input vga_csr_pkg::timing_t vscan,
	output logic active,
	output logic hsync,
	output logic vsync,
	output logic frame_start
);
	import vga_csr_pkg::*;

	timing_t h_cnt; // Pixel within line.
	timing_t v_cnt; // Line within frame.
	logic h_last;
	logic v_last;

	// Compare with >= so a shrunk scan length still wraps.
	assign h_last = (h_cnt >= hscan - 11'd1);
	assign v_last = (v_cnt >= vscan - 11'd1);

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (!enable) begin
			h_cnt <= '0; // Parked while output is off.
			v_cnt <= '0;
		end else if (pix_ce) begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 11'd1;
			end else begin
				h_cnt <= h_cnt + 11'd1;
			end
		end
	end

	always_comb begin
		active = enable && (h_cnt < hres) && (v_cnt < vres);
		hsync = enable && (h_cnt >= hsync_start) && (h_cnt < hsync_end); // End exclusive.
		vsync = enable && (v_cnt >= vsync_start) && (v_cnt < vsync_end);
		frame_start = enable && pix_ce && h_last && v_last; // Both wrap here.
	end

	// Frame start is a pixel step that lands the raster on its origin.
	a_frame_on_ce: assert property (@(posedge sys_clk) disable iff (!arst_n)
		frame_start |-> pix_ce ##1 (h_cnt == '0 && v_cnt == '0));

endmodule

//--- source/vga_video_pkg.sv
// VGA video engine types
`include "vga_consts.svh"

package vga_video_pkg;

	typedef enum logic [1:0] {
		F_IDLE = 2'd0, // Waiting for FIFO room.
		F_REQ = 2'd1, // Strobe out, waiting for ack.
		F_DATA = 2'd2, // Taking burst beats.
		F_DONE = 2'd3 // Frame fetched, waiting for frame start.
	} fetch_state_e;

	typedef logic [63:0] fb_word_t; // Four pixels per word.

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef logic [$clog2(`VGA_FIFO_DEPTH):0] fifo_cnt_t; // Holds 0 to depth.

endpackage
